// ==== rtl/refill_defines.svh ====
`ifndef REFILL_DEFINES_SVH
`define REFILL_DEFINES_SVH

// byte address width
`define REFILL_ADDR_W   64

// 8-byte lines
`define REFILL_OFFSET_W 3

// 16 sets per store
`define REFILL_INDEX_W  4

// whatever is left above index and offset
`define REFILL_TAG_W    (`REFILL_ADDR_W - `REFILL_INDEX_W - `REFILL_OFFSET_W)

`endif

// ==== rtl/refill_pkg.sv ====
`include "refill_defines.svh"

package refill_pkg;

    // address parts
    typedef logic [`REFILL_ADDR_W-1:0]  addr_t;
    typedef logic [`REFILL_INDEX_W-1:0] index_t;
    typedef logic [`REFILL_TAG_W-1:0]   tag_t;

    // instruction refill
    typedef enum logic {
        ist_idle = 1'b0,
        ist_read = 1'b1
    } icache_state_e;

    // data refill, write-back of a dirty victim comes before the read
    typedef enum logic [1:0] {
        dst_idle  = 2'b00,
        dst_miss  = 2'b01,
        dst_write = 2'b10,
        dst_read  = 2'b11
    } dcache_state_e;

endpackage

// ==== rtl/cache_tag_store.sv ====
`timescale 1ns/100ps
`include "refill_defines.svh"

module cache_tag_store #(
    parameter bit track_dirty = 1'b0
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              req_valid_i,
    input  logic              req_we_i,
    input  refill_pkg::addr_t req_addr_i,
    input  logic              fill_i,

    output logic              hit_o,
    output logic              miss_o,
    output logic              victim_dirty_o,
    output refill_pkg::addr_t victim_addr_o
);
    import refill_pkg::*;

    localparam int NUM_SETS = 1 << `REFILL_INDEX_W;
    localparam int IDX_LSB  = `REFILL_OFFSET_W;
    localparam int TAG_LSB  = `REFILL_OFFSET_W + `REFILL_INDEX_W;

    tag_t       tag_q   [2][NUM_SETS];
    logic [1:0] valid_q [NUM_SETS];
    logic [1:0] dirty_q [NUM_SETS];
    logic       lru_q   [NUM_SETS];     // way to replace next

    index_t     req_index;
    tag_t       req_tag;
    logic [1:0] way_hit;
    logic       hit_way;
    logic       victim_way;

    assign req_index = req_addr_i[TAG_LSB-1:IDX_LSB];
    assign req_tag   = req_addr_i[`REFILL_ADDR_W-1:TAG_LSB];

    // compare both ways at once
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[req_index][w] && (tag_q[w][req_index] == req_tag);
        end
    end

    assign hit_way    = way_hit[1];     // at most one way matches
    assign victim_way = lru_q[req_index];

    assign hit_o  = req_valid_i & (|way_hit);
    assign miss_o = req_valid_i & ~(|way_hit);

    // only a valid line can need a write-back
    assign victim_dirty_o = track_dirty
                          & valid_q[req_index][victim_way]
                          & dirty_q[req_index][victim_way];

    assign victim_addr_o = {tag_q[victim_way][req_index], req_index,
                            {`REFILL_OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= 2'b00;
                dirty_q[s] <= 2'b00;
                lru_q[s]   <= 1'b0;
            end
        end else if (fill_i) begin
            // new line lands in the lru way, clean
            valid_q[req_index][victim_way] <= 1'b1;
            dirty_q[req_index][victim_way] <= 1'b0;
            lru_q[req_index]               <= ~victim_way;
        end else if (hit_o) begin
            lru_q[req_index] <= ~hit_way;
            if (track_dirty && req_we_i) begin
                dirty_q[req_index][hit_way] <= 1'b1;  // write hit
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[victim_way][req_index] <= req_tag;
        end
    end

endmodule

// ==== rtl/refill_arbiter.sv ====
`timescale 1ns/100ps
`include "refill_defines.svh"

module refill_arbiter (
    input  logic              clk,
    input  logic              rst,

    input  logic              imiss_i,
    input  logic              dmiss_i,
    input  logic              victim_dirty_i,
    input  refill_pkg::addr_t iaddr_i,
    input  refill_pkg::addr_t daddr_i,
    input  refill_pkg::addr_t victim_addr_i,

    output logic              mem_re_o,
    output logic              mem_we_o,
    output refill_pkg::addr_t mem_addr_o,
    input  logic              mem_rdone_i,
    input  logic              mem_wdone_i,

    output logic              ifill_o,
    output logic              dfill_o
);
    import refill_pkg::*;

    icache_state_e ist_q;
    dcache_state_e dst_q;

    logic i_reading;
    logic d_writing;
    logic d_reading;

    function automatic addr_t line_addr(input addr_t addr);
        line_addr = {addr[`REFILL_ADDR_W-1:`REFILL_OFFSET_W], {`REFILL_OFFSET_W{1'b0}}};
    endfunction

    // instruction side only moves while the data side is idle
    always_ff @(posedge clk) begin
        if (rst) begin
            ist_q <= ist_idle;
            dst_q <= dst_idle;
        end else if (imiss_i && dst_q == dst_idle) begin
            case (ist_q)
                ist_idle: ist_q <= ist_read;
                ist_read: begin
                    if (mem_rdone_i) begin
                        ist_q <= ist_idle;
                    end
                end
            endcase
        end else if (dmiss_i) begin
            case (dst_q)
                dst_idle: dst_q <= dst_miss;
                dst_miss: begin
                    // victim state is read here, one cycle after the miss
                    if (victim_dirty_i) begin
                        dst_q <= dst_write;
                    end else begin
                        dst_q <= dst_read;
                    end
                end
                dst_write: begin
                    if (mem_wdone_i) begin
                        dst_q <= dst_read;
                    end
                end
                dst_read: begin
                    if (mem_rdone_i) begin
                        dst_q <= dst_idle;
                    end
                end
            endcase
        end
    end

    assign i_reading = (ist_q == ist_read);
    assign d_writing = (dst_q == dst_write);
    assign d_reading = (dst_q == dst_read);

    assign mem_re_o = i_reading | d_reading;
    assign mem_we_o = d_writing;

    always_comb begin
        if (i_reading) begin
            mem_addr_o = line_addr(iaddr_i);
        end else if (d_writing) begin
            mem_addr_o = victim_addr_i;   // write-back of the old line
        end else if (d_reading) begin
            mem_addr_o = line_addr(daddr_i);
        end else begin
            mem_addr_o = '0;
        end
    end

    assign ifill_o = i_reading & mem_rdone_i;
    assign dfill_o = d_reading & mem_rdone_i;

endmodule

// ==== rtl/refill_top.sv ====
`timescale 1ns/100ps

module refill_top (
    input  logic              clk,
    input  logic              rst,

    // instruction requester
    input  logic              ifetch_valid_i,
    input  refill_pkg::addr_t ifetch_addr_i,
    output logic              ifetch_hit_o,

    // data requester
    input  logic              dreq_valid_i,
    input  logic              dreq_we_i,
    input  refill_pkg::addr_t dreq_addr_i,
    output logic              dreq_hit_o,

    // memory port, level request held until done
    output logic              mem_re_o,
    output logic              mem_we_o,
    output refill_pkg::addr_t mem_addr_o,
    input  logic              mem_rdone_i,
    input  logic              mem_wdone_i
);
    import refill_pkg::*;

    logic  imiss;
    logic  dmiss;
    logic  ifill;
    logic  dfill;
    logic  victim_dirty;
    addr_t victim_addr;

    // no writes on the fetch side
    cache_tag_store #(
        .track_dirty    (1'b0)
    ) u_itags (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (ifetch_valid_i),
        .req_we_i       (1'b0),
        .req_addr_i     (ifetch_addr_i),
        .fill_i         (ifill),
        .hit_o          (ifetch_hit_o),
        .miss_o         (imiss),
        .victim_dirty_o (),
        .victim_addr_o  ()
    );

    cache_tag_store #(
        .track_dirty    (1'b1)
    ) u_dtags (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (dreq_valid_i),
        .req_we_i       (dreq_we_i),
        .req_addr_i     (dreq_addr_i),
        .fill_i         (dfill),
        .hit_o          (dreq_hit_o),
        .miss_o         (dmiss),
        .victim_dirty_o (victim_dirty),
        .victim_addr_o  (victim_addr)
    );

    refill_arbiter u_arbiter (
        .clk            (clk),
        .rst            (rst),
        .imiss_i        (imiss),
        .dmiss_i        (dmiss),
        .victim_dirty_i (victim_dirty),
        .iaddr_i        (ifetch_addr_i),
        .daddr_i        (dreq_addr_i),
        .victim_addr_i  (victim_addr),
        .mem_re_o       (mem_re_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_rdone_i    (mem_rdone_i),
        .mem_wdone_i    (mem_wdone_i),
        .ifill_o        (ifill),
        .dfill_o        (dfill)
    );

endmodule

// ==== tests/refill_vectors.svh ====
// access table, one entry per line
// columns: is_data (0 fetch, 1 data), we, pair (issue with next entry), byte address

typedef struct packed {
    logic  is_data;
    logic  we;
    logic  pair;
    logic [`REFILL_ADDR_W-1:0] addr;
} access_t;

localparam int NUM_VEC = 30;

access_t vectors [NUM_VEC];

task automatic load_vectors();
    // cold misses, then a repeat fetch to the same line
    vectors[0]  = {1'b0, 1'b0, 1'b0, 64'h0000_0000_0000_1000};
    vectors[1]  = {1'b0, 1'b0, 1'b0, 64'h0000_0000_0000_1004};
    vectors[2]  = {1'b1, 1'b0, 1'b0, 64'h0000_0000_0000_2008};

    // set 2, dirty line pushed out by two more lines
    vectors[3]  = {1'b1, 1'b1, 1'b0, 64'h0000_0000_0000_3010};
    vectors[4]  = {1'b1, 1'b0, 1'b0, 64'h0000_0000_0000_3090};
    vectors[5]  = {1'b1, 1'b0, 1'b0, 64'h0000_0000_0000_3110};

    // set 3, A B touch-A C, so B goes
    vectors[6]  = {1'b1, 1'b0, 1'b0, 64'h0000_0000_0000_4018};
    vectors[7]  = {1'b1, 1'b0, 1'b0, 64'h0000_0000_0000_4098};
    vectors[8]  = {1'b1, 1'b0, 1'b0, 64'h0000_0000_0000_401c};
    vectors[9]  = {1'b1, 1'b0, 1'b0, 64'h0000_0000_0000_4118};
    vectors[10] = {1'b1, 1'b0, 1'b0, 64'h0000_0000_0000_4018};
    vectors[11] = {1'b1, 1'b0, 1'b0, 64'h0000_0000_0000_4098};

    // fetch and data miss together
    vectors[12] = {1'b0, 1'b0, 1'b1, 64'h0000_0000_0000_5020};
    vectors[13] = {1'b1, 1'b1, 1'b0, 64'h0000_0000_0000_6028};

    // set 6 filled with dirty lines, then a pair whose data side writes back
    vectors[14] = {1'b1, 1'b1, 1'b0, 64'h0000_0000_0000_7030};
    vectors[15] = {1'b1, 1'b1, 1'b0, 64'h0000_0000_0000_70b0};
    vectors[16] = {1'b0, 1'b0, 1'b1, 64'h0000_0000_0000_8030};
    vectors[17] = {1'b1, 1'b0, 1'b0, 64'h0000_0000_0000_7130};
    vectors[18] = {1'b1, 1'b0, 1'b0, 64'h0000_0000_0000_7134};
    vectors[19] = {1'b1, 1'b0, 1'b0, 64'h0000_0000_0000_71b0};

    // fetch side eviction, no write-back there
    vectors[20] = {1'b0, 1'b0, 1'b0, 64'h0000_0000_0000_1000};
    vectors[21] = {1'b0, 1'b0, 1'b0, 64'h0000_0000_0000_1080};
    vectors[22] = {1'b0, 1'b0, 1'b0, 64'h0000_0000_0000_1100};
    vectors[23] = {1'b0, 1'b0, 1'b0, 64'h0000_0000_0000_1004};

    // write hit makes a clean line dirty
    vectors[24] = {1'b1, 1'b1, 1'b0, 64'h0000_0000_0000_2008};
    vectors[25] = {1'b1, 1'b0, 1'b0, 64'h0000_0000_0000_2088};
    vectors[26] = {1'b1, 1'b0, 1'b0, 64'h0000_0000_0000_2108};

    vectors[27] = {1'b1, 1'b1, 1'b0, 64'hffff_0000_0000_1238};  // upper tag bits
    vectors[28] = {1'b0, 1'b0, 1'b1, 64'h0000_0000_0000_9040};
    vectors[29] = {1'b1, 1'b0, 1'b0, 64'h0000_0000_0000_a048};
endtask

// ==== tests/tb_refill_top.sv ====
`timescale 1ns/100ps
`include "refill_defines.svh"

module tb_refill_top;
    import refill_pkg::*;

    `include "refill_vectors.svh"

    localparam int NUM_SETS    = 1 << `REFILL_INDEX_W;
    localparam int RESET_CYC   = 16;
    localparam int CYCLE_LIMIT = NUM_VEC * 20 + RESET_CYC;

    logic  clk;
    logic  rst;
    logic  ifetch_valid_i;
    addr_t ifetch_addr_i;
    logic  ifetch_hit_o;
    logic  dreq_valid_i;
    logic  dreq_we_i;
    addr_t dreq_addr_i;
    logic  dreq_hit_o;
    logic  mem_re_o;
    logic  mem_we_o;
    addr_t mem_addr_o;
    logic  mem_rdone_i;
    logic  mem_wdone_i;

    integer seed = 56748;
    int     error_count = 0;
    int     access_count = 0;
    int     op_count = 0;
    int     cycle_count = 0;

    // expected memory operations in issue order
    bit    exp_we_q    [$];
    addr_t exp_addr_q  [$];
    bit    exp_owner_q [$];   // 1 when the data side owns the read

    // reference tag stores as [store][way][set] with store 0 for fetch
    bit   ref_valid [2][2][NUM_SETS];
    bit   ref_dirty [2][2][NUM_SETS];
    tag_t ref_tag   [2][2][NUM_SETS];
    bit   ref_lru   [2][NUM_SETS];

    // responder state
    bit    resp_busy = 1'b0;
    int    resp_wait;
    addr_t held_addr;
    bit    held_we;
    bit    held_owner;

    refill_top i_refill_top (
        .clk            (clk),
        .rst            (rst),
        .ifetch_valid_i (ifetch_valid_i),
        .ifetch_addr_i  (ifetch_addr_i),
        .ifetch_hit_o   (ifetch_hit_o),
        .dreq_valid_i   (dreq_valid_i),
        .dreq_we_i      (dreq_we_i),
        .dreq_addr_i    (dreq_addr_i),
        .dreq_hit_o     (dreq_hit_o),
        .mem_re_o       (mem_re_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_rdone_i    (mem_rdone_i),
        .mem_wdone_i    (mem_wdone_i)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // two-way lru lookup that queues the memory traffic a miss should cause
    task automatic model_access(input bit is_data, input bit we, input addr_t addr,
                                output bit miss);
        index_t idx;
        tag_t   tag;
        bit     s;
        bit     hit_way;
        bit     v;
        idx  = addr[`REFILL_OFFSET_W +: `REFILL_INDEX_W];
        tag  = addr[`REFILL_ADDR_W-1 -: `REFILL_TAG_W];
        s    = is_data;
        miss = 1'b1;
        hit_way = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[s][w][idx] && ref_tag[s][w][idx] == tag) begin
                miss    = 1'b0;
                hit_way = w[0];
            end
        end
        if (!miss) begin
            ref_lru[s][idx] = !hit_way;
            if (is_data && we) ref_dirty[s][hit_way][idx] = 1'b1;
        end else begin
            v = ref_lru[s][idx];
            if (is_data && ref_valid[s][v][idx] && ref_dirty[s][v][idx]) begin
                exp_we_q.push_back(1'b1);
                exp_addr_q.push_back({ref_tag[s][v][idx], idx, {`REFILL_OFFSET_W{1'b0}}});
                exp_owner_q.push_back(1'b1);
            end
            exp_we_q.push_back(1'b0);
            exp_addr_q.push_back({addr[`REFILL_ADDR_W-1:`REFILL_OFFSET_W],
                                  {`REFILL_OFFSET_W{1'b0}}});
            exp_owner_q.push_back(is_data);
            ref_valid[s][v][idx] = 1'b1;
            ref_tag[s][v][idx]   = tag;
            ref_dirty[s][v][idx] = is_data && we;  // a write marks it on its hit cycle
            ref_lru[s][idx]      = !v;
        end
    endtask

    // memory responder answering in 1 to 6 cycles
    always @(negedge clk) begin
        if (rst) begin
            assert (!mem_re_o && !mem_we_o) else begin
                $display("error: memory request raised during reset");
                error_count++;
            end
        end else if (mem_rdone_i || mem_wdone_i) begin
            mem_rdone_i = 1'b0;
            mem_wdone_i = 1'b0;
            resp_busy   = 1'b0;
            op_count++;
            if (!held_we && held_owner) begin
                assert (dreq_hit_o) else begin
                    $display("mismatch dreq_hit_o after read done: got %h, expected %h",
                             dreq_hit_o, 1'b1);
                    error_count++;
                end
            end else if (!held_we) begin
                assert (ifetch_hit_o) else begin
                    $display("mismatch ifetch_hit_o after read done: got %h, expected %h",
                             ifetch_hit_o, 1'b1);
                    error_count++;
                end
            end
        end else if (mem_re_o || mem_we_o) begin
            assert (!(mem_re_o && mem_we_o)) else begin
                $display("error: read and write requested at the same time");
                error_count++;
            end
            if (!resp_busy) begin
                if (exp_addr_q.size() == 0) begin
                    $display("error: unexpected memory operation at %h", mem_addr_o);
                    error_count++;
                    held_owner = 1'b0;
                end else begin
                    assert (mem_we_o == exp_we_q[0]) else begin
                        $display("mismatch mem_we_o: got %h, expected %h",
                                 mem_we_o, exp_we_q[0]);
                        error_count++;
                    end
                    assert (mem_addr_o == exp_addr_q[0]) else begin
                        $display("mismatch mem_addr_o: got %h, expected %h",
                                 mem_addr_o, exp_addr_q[0]);
                        error_count++;
                    end
                    held_owner = exp_owner_q.pop_front();
                    void'(exp_we_q.pop_front());
                    void'(exp_addr_q.pop_front());
                end
                held_addr = mem_addr_o;
                held_we   = mem_we_o;
                resp_busy = 1'b1;
                resp_wait = 1 + ({$random(seed)} % 6);
            end else begin
                assert (mem_addr_o == held_addr) else begin
                    $display("mismatch mem_addr_o while held: got %h, expected %h",
                             mem_addr_o, held_addr);
                    error_count++;
                end
                assert (mem_we_o == held_we && mem_re_o == !held_we) else begin
                    $display("error: request type changed before done");
                    error_count++;
                end
            end
            if (resp_wait <= 1) begin
                if (held_we) mem_wdone_i = 1'b1;
                else mem_rdone_i = 1'b1;
            end else begin
                resp_wait--;
            end
        end else begin
            assert (!resp_busy) else begin
                $display("error: memory request dropped before done");
                error_count++;
            end
            resp_busy = 1'b0;
        end
    end

    initial begin
        int    i;
        int    n;
        bit    use_f;
        bit    use_d;
        bit    f_miss;
        bit    d_miss;
        bit    miss;
        bit    d_we;
        addr_t f_addr;
        addr_t d_addr;

        rst            = 1'b1;
        ifetch_valid_i = 1'b0;
        ifetch_addr_i  = '0;
        dreq_valid_i   = 1'b0;
        dreq_we_i      = 1'b0;
        dreq_addr_i    = '0;
        mem_rdone_i    = 1'b0;
        mem_wdone_i    = 1'b0;
        load_vectors();
        repeat (RESET_CYC) @(negedge clk);
        rst = 1'b0;

        i = 0;
        while (i < NUM_VEC) begin
            n      = vectors[i].pair ? 2 : 1;
            use_f  = 1'b0;
            use_d  = 1'b0;
            f_miss = 1'b0;
            d_miss = 1'b0;
            d_we   = 1'b0;
            f_addr = '0;
            d_addr = '0;
            for (int k = i; k < i + n; k++) begin
                model_access(vectors[k].is_data, vectors[k].we, vectors[k].addr, miss);
                if (vectors[k].is_data) begin
                    use_d  = 1'b1;
                    d_we   = vectors[k].we;
                    d_addr = vectors[k].addr;
                    d_miss = miss;
                end else begin
                    use_f  = 1'b1;
                    f_addr = vectors[k].addr;
                    f_miss = miss;
                end
            end

            @(negedge clk);
            ifetch_valid_i = use_f;
            ifetch_addr_i  = f_addr;
            dreq_valid_i   = use_d;
            dreq_we_i      = d_we;
            dreq_addr_i    = d_addr;

            @(negedge clk);
            if (use_f) begin
                assert (ifetch_hit_o == !f_miss) else begin
                    $display("mismatch ifetch_hit_o entry %0d: got %h, expected %h",
                             i, ifetch_hit_o, !f_miss);
                    error_count++;
                end
            end
            if (use_d) begin
                assert (dreq_hit_o == !d_miss) else begin
                    $display("mismatch dreq_hit_o entry %0d: got %h, expected %h",
                             i + n - 1, dreq_hit_o, !d_miss);
                    error_count++;
                end
            end
            // held until every active port hits
            while ((use_f && !ifetch_hit_o) || (use_d && !dreq_hit_o)) @(negedge clk);
            access_count += n;
            i += n;
        end

        @(negedge clk);
        ifetch_valid_i = 1'b0;
        dreq_valid_i   = 1'b0;
        repeat (2) @(negedge clk);
        assert (exp_addr_q.size() == 0 && !resp_busy) else begin
            $display("error: %0d expected memory operations never completed",
                     exp_addr_q.size());
            error_count++;
        end

        $display("accesses %0d, memory operations %0d, errors %0d",
                 access_count, op_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            error_count++;
            $display("error: timeout after %0d cycles, fetch state %s, data state %s",
                     cycle_count, i_refill_top.u_arbiter.ist_q.name(),
                     i_refill_top.u_arbiter.dst_q.name());
            $display("accesses %0d, memory operations %0d, errors %0d",
                     access_count, op_count, error_count);
            $display("TEST FAIL");
            $finish;
        end
    end

endmodule

// ==== list.f ====
+incdir+rtl
+incdir+tests
rtl/refill_pkg.sv
rtl/cache_tag_store.sv
rtl/refill_arbiter.sv
rtl/refill_top.sv
tests/tb_refill_top.sv
